//--- logic/intExecPkg.sv
// Shared types for the integer execution stage.
// Operands arrive already resolved; there is no bypass network.
// The valid flag must stay the first member of every registered payload.
`default_nettype none

package intExecPkg;

    // ISA widths
    localparam int dataWidth = 32;
    localparam int insnBytes = 4;
    localparam int shiftAmtWidth = 5;
    localparam int brDispWidth = 20;

    typedef logic [dataWidth-1:0] dataWord;

    typedef enum logic [2:0] {
        opAlu,
        opShift,
        opBr,   // PC-relative branch or jump
        opRij,  // register-indirect jump
        opSel   // conditional select, also the default
    } intOpType;

    typedef enum logic [2:0] {
        condEq, condNe, condLt, condLtu, condGe, condGeu, condAl
    } condCode;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluLui
    } aluCode;

    typedef enum logic [1:0] {
        shiftSll, shiftSrl, shiftSra
    } shiftKind;

    typedef enum logic {
        operandReg, operandImm
    } operandKind;

    typedef struct packed {
        logic    ready;
        dataWord data;
    } operand;

    typedef struct packed {
        logic    predTaken;
        dataWord predTarget;
    } branchPred;

    typedef struct packed {
        logic                     valid;
        intOpType                 opType;
        condCode                  cond;
        aluCode                   aluFn;
        shiftKind                 shiftFn;
        logic [shiftAmtWidth-1:0] shiftAmt;
        logic                     useImmShift;  // immediate amount instead of operand B
        operandKind               kindA;
        operandKind               kindB;
        operand                   opA;
        operand                   opB;
        dataWord                  pc;
        logic [brDispWidth-1:0]   brDisp;
        branchPred                pred;
    } issuedOp;

    typedef struct packed {
        logic    valid;
        logic    isCondBr;
        dataWord brAddr;
        dataWord nextAddr;
        logic    execTaken;
        logic    predTaken;
        logic    mispred;
    } branchResult;

    // Result ready low means the op must be replayed
    typedef struct packed {
        logic        valid;
        operand      result;
        branchResult br;
        intOpType    opType;
    } writebackOp;

endpackage

`default_nettype wire

//--- logic/pipeStageReg.sv
// Pipeline register for any packed payload whose first member is valid.
// Only valid is reset; the rest of the payload loads whenever stall is low.
// Clear drops valid on the next edge, stalled or not.
`timescale 1ns/100ps
`default_nettype none

module pipeStageReg #(
    parameter type payloadType = logic [1:0]
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       stall,
    input  logic       clear,
    input  payloadType d,
    output payloadType q
);

    localparam int payloadWidth = $bits(payloadType);

    logic [payloadWidth-1:0] dBits;
    logic                    validQ;
    logic [payloadWidth-2:0] bodyQ;

    assign dBits = d;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (clear) begin
            validQ <= 1'b0;
        end else if (!stall) begin
            validQ <= dBits[payloadWidth-1];
        end
    end

    // Payload body
    always_ff @(posedge clk) begin
        if (!stall) begin
            bodyQ <= dBits[payloadWidth-2:0];
        end
    end

    assign q = payloadType'({validQ, bodyQ});

endmodule

`default_nettype wire

//--- logic/intArithUnit.sv
// ALU and shifter for one integer op, purely combinational.
// Register shift amounts use only the low five bits of operand B.
`timescale 1ns/100ps
`default_nettype none

module intArithUnit (
    input  intExecPkg::issuedOp   op,
    output intExecPkg::dataWord   arithResult
);

    import intExecPkg::*;

    dataWord                  srcA;
    dataWord                  srcB;
    dataWord                  aluResult;
    dataWord                  shifterResult;
    logic [shiftAmtWidth-1:0] shiftAmt;
    logic                     sltBit;
    logic                     sltuBit;

    assign srcA = op.opA.data;
    assign srcB = op.opB.data;

    // Compare results for SLT and SLTU
    assign sltBit  = $signed(srcA) < $signed(srcB);
    assign sltuBit = srcA < srcB;

    always_comb begin
        case (op.aluFn)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, sltBit};
            aluSltu: aluResult = {{(dataWidth-1){1'b0}}, sltuBit};
            default: aluResult = srcB;  // LUI passes the immediate through
        endcase
    end

    assign shiftAmt = op.useImmShift ? op.shiftAmt : srcB[shiftAmtWidth-1:0];

    always_comb begin
        case (op.shiftFn)
            shiftSll: shifterResult = srcA << shiftAmt;
            shiftSrl: shifterResult = srcA >> shiftAmt;
            default:  shifterResult = $signed(srcA) >>> shiftAmt;
        endcase
    end

    // Non-arithmetic ops ignore this output
    assign arithResult = (op.opType == opShift) ? shifterResult : aluResult;

endmodule

`default_nettype wire

//--- logic/branchResolver.sv
// Branch condition, target and misprediction check, purely combinational.
// The valid field of the result is left low here; the top level qualifies it.
// condTrue also drives the conditional select of non-branch ops.
`timescale 1ns/100ps
`default_nettype none

module branchResolver (
    input  intExecPkg::issuedOp     op,
    output logic                    condTrue,
    output intExecPkg::branchResult result
);

    import intExecPkg::*;

    dataWord srcA;
    dataWord srcB;
    dataWord dispExt;
    dataWord brTarget;
    dataWord rijSum;
    dataWord fallThrough;
    logic    isBranch;
    logic    isJump;
    logic    taken;

    assign srcA = op.opA.data;
    assign srcB = op.opB.data;

    always_comb begin
        case (op.cond)
            condEq:  condTrue = (srcA == srcB);
            condNe:  condTrue = (srcA != srcB);
            condLt:  condTrue = ($signed(srcA) < $signed(srcB));
            condLtu: condTrue = (srcA < srcB);
            condGe:  condTrue = ($signed(srcA) >= $signed(srcB));
            condGeu: condTrue = (srcA >= srcB);
            default: condTrue = 1'b1;  // AL
        endcase
    end

    assign isBranch = (op.opType == opBr) || (op.opType == opRij);
    assign isJump   = (op.opType == opRij) || (op.opType == opBr && op.cond == condAl);
    assign taken    = isBranch && condTrue;

    // Displacement sign extension
    assign dispExt = {{(dataWidth-brDispWidth){op.brDisp[brDispWidth-1]}}, op.brDisp};

    assign brTarget    = op.pc + (dispExt << 1);
    assign rijSum      = srcA + dispExt;
    assign fallThrough = op.pc + dataWidth'(insnBytes);

    always_comb begin
        result.valid     = 1'b0;
        result.isCondBr  = !isJump;
        result.brAddr    = op.pc;
        result.execTaken = taken;
        result.predTaken = op.pred.predTaken;

        if (!taken) begin
            result.nextAddr = fallThrough;
        end else if (op.opType == opBr) begin
            result.nextAddr = brTarget;
        end else begin
            // JALR style, bit 0 forced low
            result.nextAddr = {rijSum[dataWidth-1:1], 1'b0};
        end

        // Direction miss, or taken to the wrong place
        result.mispred = (op.pred.predTaken != taken) ||
                         (taken && op.pred.predTarget != result.nextAddr);
    end

endmodule

`default_nettype wire

//--- logic/intExecStage.sv
// Integer execution stage with a fixed latency of two clock edges.
// Stall freezes both registers; the source must hold issue while stalled.
// Clear empties the stage on the next edge.
`timescale 1ns/100ps
`default_nettype none

module intExecStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  logic                   clear,
    input  intExecPkg::issuedOp    issue,
    output intExecPkg::writebackOp writeback
);

    import intExecPkg::*;

    issuedOp     stageOp;
    dataWord     arithResult;
    logic        condTrue;
    branchResult brRaw;
    logic        regReady;
    logic        isBranch;
    writebackOp  nextWb;

    pipeStageReg #(.payloadType(issuedOp)) i_inReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .clear (clear),
        .d     (issue),
        .q     (stageOp)
    );

    intArithUnit i_arith (
        .op          (stageOp),
        .arithResult (arithResult)
    );

    branchResolver i_branch (
        .op       (stageOp),
        .condTrue (condTrue),
        .result   (brRaw)
    );

    // Result combining
    always_comb begin
        // A register source that was not ready forces a replay
        regReady = (stageOp.kindA != operandReg || stageOp.opA.ready) &&
                   (stageOp.kindB != operandReg || stageOp.opB.ready);
        isBranch = (stageOp.opType == opBr) || (stageOp.opType == opRij);

        nextWb.valid        = stageOp.valid;
        nextWb.opType       = stageOp.opType;
        nextWb.result.ready = regReady;

        case (stageOp.opType)
            opAlu, opShift: nextWb.result.data = arithResult;
            opBr, opRij:    nextWb.result.data = stageOp.pc + dataWidth'(insnBytes);
            default:        nextWb.result.data = condTrue ? stageOp.opA.data
                                                          : stageOp.opB.data;
        endcase

        nextWb.br         = brRaw;
        nextWb.br.valid   = stageOp.valid && isBranch && regReady;
        nextWb.br.mispred = nextWb.br.valid && brRaw.mispred;
    end

    pipeStageReg #(.payloadType(writebackOp)) i_outReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .clear (clear),
        .d     (nextWb),
        .q     (writeback)
    );

endmodule

`default_nettype wire

//--- dv/intExecStage_properties.sv
// Concurrent checks on the stage outputs, attached to intExecStage with bind.
// All checks are off while reset is asserted.
`timescale 1ns/100ps
`default_nettype none

module intExecStage_properties (
    input logic                   clk,
    input logic                   rstN,
    input logic                   stall,
    input logic                   clear,
    input intExecPkg::writebackOp writeback
);

    // Clear empties the stage on the next edge
    clearEmptiesStage: assert property (@(posedge clk) disable iff (!rstN)
        clear |=> !writeback.valid)
        else $error("writeback valid in the cycle after clear");

    mispredNeedsBranch: assert property (@(posedge clk) disable iff (!rstN)
        writeback.br.mispred |-> writeback.br.valid)
        else $error("mispred set without branch valid");

    // A stalled edge leaves writeback unchanged
    stallHoldsWriteback: assert property (@(posedge clk) disable iff (!rstN)
        stall && !clear |=> $stable(writeback))
        else $error("writeback changed under stall");

endmodule

`default_nettype wire

//--- dv/intExecTb.sv
// Directed testbench for the integer execution stage.
// Each op is checked on the second edge after it is driven; the first mismatch ends the run.
// Expected values come from reference functions written from the ISA rules.
`timescale 1ns/100ps
`default_nettype none

module intExecTb;

    import intExecPkg::*;

    localparam int resetCycles = 16;
    localparam int stallCycles = 4;
    // 62 single ops of three cycles each, plus the stall and clear sequence
    localparam int timeoutCycles = (resetCycles + 62 * 3 + 16) * 3 / 2;
    // Signed and unsigned edge pairs for the select test
    localparam logic [31:0] selEdgeA [4] = '{32'h0, 32'h8000_0000, 32'h1, 32'hffff_ffff};
    localparam logic [31:0] selEdgeB [4] = '{32'h0, 32'h1, 32'h8000_0000, 32'h0};

    logic        clk;
    logic        rstN;
    logic        stall;
    logic        clear;
    issuedOp     issue;
    writebackOp  writeback;
    logic [31:0] rngState;
    int          cycleCount = 0;

    intExecStage i_intExecStage (.clk(clk), .rstN(rstN), .stall(stall), .clear(clear),
                                 .issue(issue), .writeback(writeback));

    bind intExecStage intExecStage_properties i_props (.clk(clk), .rstN(rstN), .stall(stall),
                                                      .clear(clear), .writeback(writeback));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run is still going after %0d cycles", timeoutCycles);
            $display("TEST FAILED");
            $fatal(1, "Cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshiftNext();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Issue one op and collect its writeback after the second edge
    task automatic runOp(input issuedOp op, output writebackOp wb);
        @(posedge clk);
        #2 issue = op;
        @(posedge clk);
        #2 issue.valid = 1'b0;
        @(posedge clk);
        #1 wb = writeback;
    endtask

    // Valid op with ready register operands and random data
    function automatic issuedOp newOp(input intOpType opType);
        issuedOp op;
        op = '0;
        op.valid = 1'b1;
        op.opType = opType;
        op.opA = '{1'b1, xorshiftNext()};
        op.opB = '{1'b1, xorshiftNext()};
        op.pc = xorshiftNext() & 32'hffff_fffc;
        return op;
    endfunction

    function automatic logic refCond(input issuedOp op);
        logic [31:0] a;
        logic [31:0] b;
        a = op.opA.data;
        b = op.opB.data;
        case (op.cond)
            condEq:  return a == b;
            condNe:  return a != b;
            condLt:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
            condLtu: return a < b;
            condGe:  return !((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
            condGeu: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] refArith(input issuedOp op);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  amt;
        a = op.opA.data;
        b = op.opB.data;
        amt = op.useImmShift ? op.shiftAmt : b[4:0];
        if (op.opType == opShift) begin
            case (op.shiftFn)
                shiftSll: return a << amt;
                shiftSrl: return a >> amt;
                default:  return (a >> amt) | (a[31] ? ~(32'hffff_ffff >> amt) : 32'h0);
            endcase
        end
        case (op.aluFn)
            aluAdd:  return a + b;
            aluSub:  return a + ~b + 32'd1;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSlt:  return (a[31] != b[31]) ? 32'(a[31]) : 32'(a < b);
            aluSltu: return 32'(a < b);
            default: return b;
        endcase
    endfunction

    task automatic aluShiftTest();
        issuedOp    op;
        writebackOp wb;
        for (int k = 0; k < 22; k++) begin
            if (k < 16) begin
                op = newOp(opAlu);
                op.aluFn = aluCode'(3'(k / 2));
            end else begin
                op = newOp(opShift);
                op.shiftFn = shiftKind'(2'((k - 16) / 2));
                op.useImmShift = k[0];
                op.shiftAmt = op.pc[6:2];
            end
            runOp(op, wb);
            checkValue("aluShift", {29'd0, 1'b1, 1'b1, 1'b0, refArith(op)},
                       {29'd0, wb.valid, wb.result.ready, wb.br.valid, wb.result.data});
        end
    endtask

    // predMode 0 is a correct prediction, 1 a wrong direction, 2 a wrong target
    task automatic branchCase(input intOpType opType, input condCode cond,
                              input logic [31:0] a, input logic [31:0] b, input int predMode);
        issuedOp     op;
        writebackOp  wb;
        logic        taken;
        logic [31:0] target;
        op = newOp(opType);
        op.cond = cond;
        op.opA.data = a;
        op.opB.data = b;
        op.brDisp = 20'(xorshiftNext());
        taken = refCond(op);
        target = !taken ? op.pc + 32'd4
               : (opType == opBr) ? op.pc + {{11{op.brDisp[19]}}, op.brDisp, 1'b0}
               : (a + {{12{op.brDisp[19]}}, op.brDisp}) & 32'hffff_fffe;
        op.pred.predTaken = (predMode == 1) ? !taken : (predMode == 2) ? 1'b1 : taken;
        op.pred.predTarget = (predMode == 2) ? target ^ 32'h100 : target;
        runOp(op, wb);
        checkValue("branch", {27'd0, 1'b1, taken, predMode != 0,
                              !(opType == opRij || cond == condAl), 1'b1, target},
                   {27'd0, wb.br.valid, wb.br.execTaken, wb.br.mispred, wb.br.isCondBr,
                    wb.result.ready, wb.br.nextAddr});
        checkValue("branchLink", {32'd0, op.pc + 32'd4}, {32'd0, wb.result.data});
        // Op type, prediction and branch address pass through unchanged
        checkValue("branchInfo", {28'd0, opType, op.pred.predTaken, op.pc},
                   {28'd0, wb.opType, wb.br.predTaken, wb.br.brAddr});
    endtask

    task automatic branchTest();
        branchCase(opBr, condEq, 32'h1234, 32'h1234, 0);
        branchCase(opBr, condLt, 32'h7fff_ffff, 32'h8000_0000, 0);
        branchCase(opBr, condAl, xorshiftNext(), xorshiftNext(), 0);
        branchCase(opRij, condAl, xorshiftNext() | 32'h1, 32'h0, 0);
        branchCase(opBr, condGeu, xorshiftNext(), xorshiftNext(), 0);
        branchCase(opBr, condNe, 32'h5, 32'h5, 0);
        // One direction miss, one target miss, one hit
        branchCase(opBr, condLtu, 32'h1, 32'h2, 1);
        branchCase(opRij, condAl, xorshiftNext(), 32'h0, 2);
        branchCase(opBr, condGe, 32'h0, 32'hffff_ffff, 0);
    endtask

    task automatic selTest();
        issuedOp     op;
        writebackOp  wb;
        logic [31:0] expData;
        for (int c = 0; c < 7; c++) begin
            for (int e = 0; e < 4; e++) begin
                op = newOp(opSel);
                op.cond = condCode'(3'(c));
                op.opA.data = selEdgeA[e];
                op.opB.data = selEdgeB[e];
                expData = refCond(op) ? op.opA.data : op.opB.data;
                runOp(op, wb);
                checkValue("select", {30'd0, 1'b1, 1'b0, expData},
                           {30'd0, wb.result.ready, wb.br.valid, wb.result.data});
            end
        end
    endtask

    // Unready REG operands force a replay, an unready IMM operand does not
    task automatic replayTest();
        issuedOp    op;
        writebackOp wb;
        for (int k = 0; k < 3; k++) begin
            op = newOp(opBr);
            op.cond = condAl;
            op.pred.predTaken = 1'b0;
            op.opA.ready = (k == 1);
            op.opB.ready = (k != 1);
            op.kindA = (k == 2) ? operandImm : operandReg;
            runOp(op, wb);
            checkValue("replay", {60'd0, 1'b1, k == 2, k == 2, k == 2},
                       {60'd0, wb.valid, wb.result.ready, wb.br.valid, wb.br.mispred});
        end
    endtask

    task automatic stallClearTest();
        issuedOp    op;
        writebackOp held;
        op = newOp(opAlu);
        op.aluFn = aluXor;
        @(posedge clk);
        #2 issue = op;
        @(posedge clk);
        // Op now waits in the input register
        #2 issue.valid = 1'b0;
        stall = 1'b1;
        held = writeback;
        repeat (stallCycles) begin
            @(posedge clk);
            #1 checkValue("stallHold", {31'd0, held.valid, held.result.data},
                          {31'd0, writeback.valid, writeback.result.data});
        end
        #1 stall = 1'b0;
        @(posedge clk);
        #1 checkValue("stallRelease", {31'd0, 1'b1, refArith(op)},
                      {31'd0, writeback.valid, writeback.result.data});
        // Two ops in flight, then clear
        #1 issue = op;
        @(posedge clk);
        #2 issue = newOp(opSel);
        @(posedge clk);
        #1 checkValue("clearBefore", 64'd1, {63'd0, writeback.valid});
        // Issue stays valid across the clear edge
        #1 clear = 1'b1;
        @(posedge clk);
        #1 checkValue("clearFirst", 64'd0, {63'd0, writeback.valid});
        #1 clear = 1'b0;
        issue.valid = 1'b0;
        @(posedge clk);
        #1 checkValue("clearSecond", 64'd0, {63'd0, writeback.valid});
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        issue = '0;
        rngState = 32'hc2ea;
        repeat (resetCycles) @(posedge clk);
        #2 rstN = 1'b1;
        aluShiftTest();
        branchTest();
        selTest();
        replayTest();
        stallClearTest();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/intExecPkg.sv
logic/pipeStageReg.sv
logic/intArithUnit.sv
logic/branchResolver.sv
logic/intExecStage.sv
dv/intExecStage_properties.sv
dv/intExecTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the success line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module intExecTb -f src.f -o intExecSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/intExecSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
